//--- vga_pattern.f
src/vga_pkg.sv
src/vga_pos_if.sv
src/vga_pixel_if.sv
src/vga_timing.sv
src/vga_pattern_gen.sv
src/vga_out_stage.sv
src/vga_top.sv
testbench/vga_chk.sv
testbench/vga_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the vga_pattern simulation with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module vga_tb -f vga_pattern.f \
  --Mdir obj_dir -o vga_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/vga_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "^Result: PASSED$" "$LOG"; then
  exit 0
fi
echo "Simulation failed (exit status $sim_status)"
exit 1

//--- testbench/vga_tb.sv
`timescale 1ns/1ps

module vga_tb;

  // Tiny frame, 24 x 13 clocks
  localparam int HACTIVE   = 16;
  localparam int HFP       = 2;
  localparam int HSLEN     = 3;
  localparam int HBP       = 3;
  localparam int VACTIVE   = 8;
  localparam int VFP       = 1;
  localparam int VSLEN     = 2;
  localparam int VBP       = 2;
  localparam int HPOL      = 0;
  localparam int VPOL      = 1;
  localparam int CELL_LOG2 = 1;

  localparam int HTOTAL     = HACTIVE + HFP + HSLEN + HBP;
  localparam int VTOTAL     = VACTIVE + VFP + VSLEN + VBP;
  localparam int FRAMES     = 12;
  localparam int RUN_CYCLES = FRAMES * HTOTAL * VTOTAL;
  localparam int TIMEOUT    = RUN_CYCLES + 100;

  logic           pclk;
  logic           rst_n_i;
  vga_pkg::mode_t mode_i;
  vga_pkg::rgb_t  color_i;
  vga_pkg::rgb_t  rgb_o;
  logic           hsync_o;
  logic           vsync_o;
  logic           blank_o;

  // Model state
  int             m_h;
  int             m_v;
  int             frame_cnt;
  int             fail_count;
  int             cycle_cnt;
  int             mode_px [4];
  logic [31:0]    rng_state;
  vga_pkg::mode_t lat_mode;
  vga_pkg::rgb_t  lat_color;

  // Expected pattern register contents
  vga_pkg::rgb_t  e1_rgb;
  logic           e1_hs;
  logic           e1_vs;
  logic           e1_bl;
  vga_pkg::mode_t e1_mode;
  string          e1_tag;

  vga_top #(
    .HACTIVE (HACTIVE), .HFP (HFP), .HSLEN (HSLEN), .HBP (HBP),
    .VACTIVE (VACTIVE), .VFP (VFP), .VSLEN (VSLEN), .VBP (VBP),
    .HPOL (HPOL), .VPOL (VPOL), .CELL_LOG2 (CELL_LOG2)
  ) vga_top_i (
    .pclk (pclk), .rst_n_i (rst_n_i), .mode_i (mode_i), .color_i (color_i),
    .rgb_o (rgb_o), .hsync_o (hsync_o), .vsync_o (vsync_o), .blank_o (blank_o)
  );

  initial begin
    pclk = 1'b0;
    forever #10 pclk = ~pclk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic string mode_name(input vga_pkg::mode_t m);
    case (m)
      vga_pkg::MODE_SOLID: return "solid";
      vga_pkg::MODE_BARS:  return "bars";
      vga_pkg::MODE_CHECK: return "checker";
      default:             return "gradient";
    endcase
  endfunction

  // Reference colour for one position
  function automatic vga_pkg::rgb_t expected_color(input int x, input int y,
                                                   input vga_pkg::mode_t m,
                                                   input vga_pkg::rgb_t c);
    int bar;
    vga_pkg::chan_t r;
    vga_pkg::chan_t g;
    vga_pkg::chan_t b;
    bar = x / (HACTIVE / 8);
    r = ((bar % 2) == 1) ? 4'hF : 4'h0;
    g = (((bar / 2) % 2) == 1) ? 4'hF : 4'h0;
    b = (((bar / 4) % 2) == 1) ? 4'hF : 4'h0;
    case (m)
      vga_pkg::MODE_SOLID: return c;
      vga_pkg::MODE_BARS:  return {r, g, b};
      vga_pkg::MODE_CHECK: begin
        if (((x >> CELL_LOG2) % 2) != ((y >> CELL_LOG2) % 2)) return 12'hFFF;
        return 12'h000;
      end
      default: return {vga_pkg::chan_t'(x % 16), vga_pkg::chan_t'(y % 16), c[3:0]};
    endcase
  endfunction

  task automatic check_rgb(input string name, input vga_pkg::rgb_t exp,
                           input vga_pkg::rgb_t act);
    if (act !== exp) begin
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
      $display("Result: FAILED");
      $fatal(1, "rgb_o differs from the model");
    end
  endtask

  task automatic check_sync(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Mismatch %s: expected %b, actual %b", name, exp, act);
      $display("Result: FAILED");
      $fatal(1, "timing level differs from the model");
    end
  endtask

  // Fixed mode at each frame start, random changes inside the frame
  task automatic drive_inputs();
    rng_state = xorshift32(rng_state);
    if ((m_h == 0) && (m_v == 0)) begin
      mode_i = vga_pkg::mode_t'(frame_cnt % 4);
    end else if (rng_state[3:0] == 4'd0) begin
      mode_i = rng_state[5:4];
    end
    if (rng_state[9:7] == 3'd0) begin
      color_i = rng_state[31:20];
    end
  endtask

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT) begin
      @(posedge pclk);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
    $display("Result: FAILED");
    $fatal(1, "timeout");
  end

  // Watch the bound checker for failed assertions
  initial begin
    forever begin
      @(posedge pclk);
      #1;
      if (vga_top_i.chk_i.err_cnt != 0) begin
        $display("An assertion in the bound checker failed near cycle %0d", cycle_cnt);
        $display("Result: FAILED");
        $fatal(1, "bound assertion failed");
      end
    end
  end

  initial begin
    vga_pkg::rgb_t  e2_rgb;
    logic           e2_hs;
    logic           e2_vs;
    logic           e2_bl;
    vga_pkg::mode_t e2_mode;
    string          e2_tag;
    rst_n_i   = 1'b1;
    mode_i    = vga_pkg::MODE_SOLID;
    color_i   = '0;
    rng_state = 32'h7f6a_4e23;
    m_h = 0;
    m_v = 0;
    frame_cnt  = 0;
    fail_count = 0;
    foreach (mode_px[i]) mode_px[i] = 0;
    lat_mode  = vga_pkg::MODE_SOLID;
    lat_color = '0;
    e1_rgb  = '0;
    e1_hs   = 1'b0;
    e1_vs   = 1'b0;
    e1_bl   = 1'b1;
    e1_mode = vga_pkg::MODE_SOLID;
    e1_tag  = "after reset";

    // A clean falling edge puts the asynchronous reset in force before the first clock
    #1;
    rst_n_i = 1'b0;

    // Outputs idle while reset is held
    repeat (4) begin
      @(posedge pclk);
      #1;
      check_rgb("after reset rgb_o", 12'h000, rgb_o);
      check_sync("after reset blank_o", 1'b1, blank_o);
      check_sync("after reset hsync_o", (HPOL == 0), hsync_o);
      check_sync("after reset vsync_o", (VPOL == 0), vsync_o);
    end
    #1;
    rst_n_i = 1'b1;

    // Two extra cycles drain the pipeline
    for (int cyc = 0; cyc < RUN_CYCLES + 2; cyc++) begin
      @(posedge pclk);
      // Output register takes the previous pattern register
      e2_rgb  = e1_bl ? 12'h000 : e1_rgb;
      e2_hs   = (HPOL != 0) ? e1_hs : !e1_hs;
      e2_vs   = (VPOL != 0) ? e1_vs : !e1_vs;
      e2_bl   = e1_bl;
      e2_mode = e1_mode;
      e2_tag  = e1_tag;
      // Frame start latches mode and colour
      if ((m_h == 0) && (m_v == 0)) begin
        lat_mode  = mode_i;
        lat_color = color_i;
        frame_cnt++;
      end
      e1_rgb  = expected_color(m_h, m_v, lat_mode, lat_color);
      e1_hs   = (m_h >= HACTIVE + HFP) && (m_h < HACTIVE + HFP + HSLEN);
      e1_vs   = (m_v >= VACTIVE + VFP) && (m_v < VACTIVE + VFP + VSLEN);
      e1_bl   = (m_h >= HACTIVE) || (m_v >= VACTIVE);
      e1_mode = lat_mode;
      e1_tag  = $sformatf("frame %0d %s x=%0d y=%0d", frame_cnt - 1,
                          mode_name(lat_mode), m_h, m_v);
      if (m_h == HTOTAL - 1) begin
        m_h = 0;
        m_v = (m_v == VTOTAL - 1) ? 0 : m_v + 1;
      end else begin
        m_h = m_h + 1;
      end
      #1;
      check_rgb({e2_tag, " rgb_o"}, e2_rgb, rgb_o);
      check_sync({e2_tag, " hsync_o"}, e2_hs, hsync_o);
      check_sync({e2_tag, " vsync_o"}, e2_vs, vsync_o);
      check_sync({e2_tag, " blank_o"}, e2_bl, blank_o);
      if (!e2_bl) mode_px[e2_mode]++;
      #1;
      drive_inputs();
    end

    for (int m = 0; m < 4; m++) begin
      if (mode_px[m] == 0) begin
        $display("No active %s pixels were checked", mode_name(vga_pkg::mode_t'(m)));
        fail_count++;
      end
    end
    if (fail_count == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      $display("Result: FAILED");
      $fatal(1, "pattern coverage incomplete");
    end
  end

endmodule

//--- testbench/vga_chk.sv
`timescale 1ns/1ps

module vga_chk #(
  parameter int HSLEN = 96,
  parameter int HPOL  = 0,
  parameter int VPOL  = 1
) (
  input logic          pclk,
  input logic          rst_n_i,
  input vga_pkg::rgb_t rgb_i,
  input logic          hsync_i,
  input logic          vsync_i,
  input logic          blank_i
);

  // Pin levels of the syncs
  localparam logic HS_ON  = (HPOL != 0);
  localparam logic HS_OFF = (HPOL == 0);
  localparam logic VS_OFF = (VPOL == 0);

  logic hs_on;
  int   hs_run;

  // Number of assertion failures so far
  int   err_cnt = 0;

  assign hs_on = (hsync_i == HS_ON);

  // Cycles already spent in the current hsync pulse
  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      hs_run <= 0;
    end else if (hs_on) begin
      hs_run <= hs_run + 1;
    end else begin
      hs_run <= 0;
    end
  end

  // Black outside the visible area
  blank_black: assert property (@(posedge pclk) disable iff (!rst_n_i)
    blank_i |-> (rgb_i == '0))
    else begin
      err_cnt++;
      $error("rgb_o is not black while blank_o is set");
    end

  // A pulse never grows past HSLEN
  hs_not_long: assert property (@(posedge pclk) disable iff (!rst_n_i)
    hs_on |-> (hs_run < HSLEN))
    else begin
      err_cnt++;
      $error("hsync_o pulse is longer than HSLEN");
    end

  // A pulse that just ended lasted exactly HSLEN
  hs_not_short: assert property (@(posedge pclk) disable iff (!rst_n_i)
    (!hs_on && (hs_run != 0)) |-> (hs_run == HSLEN))
    else begin
      err_cnt++;
      $error("hsync_o pulse is shorter than HSLEN");
    end

  // Idle outputs while in reset
  reset_levels: assert property (@(posedge pclk)
    !rst_n_i |-> ((rgb_i == '0) && blank_i && (hsync_i == HS_OFF) && (vsync_i == VS_OFF)))
    else begin
      err_cnt++;
      $error("outputs are not at their reset levels during reset");
    end

endmodule

bind vga_top vga_chk #(
  .HSLEN (HSLEN),
  .HPOL  (HPOL),
  .VPOL  (VPOL)
) chk_i (
  .pclk    (pclk),
  .rst_n_i (rst_n_i),
  .rgb_i   (rgb_o),
  .hsync_i (hsync_o),
  .vsync_i (vsync_o),
  .blank_i (blank_o)
);

//--- src/vga_top.sv
`timescale 1ns/1ps

module vga_top #(
  // 640x480 at 60 Hz
  parameter int HACTIVE   = 640,
  parameter int HFP       = 16,
  parameter int HSLEN     = 96,
  parameter int HBP       = 48,
  parameter int VACTIVE   = 480,
  parameter int VFP       = 10,
  parameter int VSLEN     = 2,
  parameter int VBP       = 33,
  // Sync polarity, 1 is active high
  parameter int HPOL      = 0,
  parameter int VPOL      = 1,
  // Checker cell of 2**CELL_LOG2 pixels
  parameter int CELL_LOG2 = 5
) (
  input  logic           pclk,
  input  logic           rst_n_i,
  input  vga_pkg::mode_t mode_i,
  input  vga_pkg::rgb_t  color_i,
  output vga_pkg::rgb_t  rgb_o,
  output logic           hsync_o,
  output logic           vsync_o,
  output logic           blank_o
);

  // Timing generator to pattern generator
  vga_pos_if pos_if ();

  // Pattern generator to output stage
  vga_pixel_if pix_if ();

  vga_timing #(
    .HACTIVE (HACTIVE),
    .HFP     (HFP),
    .HSLEN   (HSLEN),
    .HBP     (HBP),
    .VACTIVE (VACTIVE),
    .VFP     (VFP),
    .VSLEN   (VSLEN),
    .VBP     (VBP)
  ) timing_i (
    .pclk    (pclk),
    .rst_n_i (rst_n_i),
    .pos     (pos_if)
  );

  vga_pattern_gen #(
    .HACTIVE   (HACTIVE),
    .CELL_LOG2 (CELL_LOG2)
  ) pattern_i (
    .pclk    (pclk),
    .rst_n_i (rst_n_i),
    .mode_i  (mode_i),
    .color_i (color_i),
    .pos     (pos_if),
    .pix     (pix_if)
  );

  vga_out_stage #(
    .HPOL (HPOL),
    .VPOL (VPOL)
  ) out_i (
    .pclk    (pclk),
    .rst_n_i (rst_n_i),
    .pix     (pix_if),
    .rgb_o   (rgb_o),
    .hsync_o (hsync_o),
    .vsync_o (vsync_o),
    .blank_o (blank_o)
  );

endmodule

//--- src/vga_out_stage.sv
`timescale 1ns/1ps

module vga_out_stage #(
  parameter int HPOL = 0,
  parameter int VPOL = 1
) (
  input  logic          pclk,
  input  logic          rst_n_i,
  vga_pixel_if.dst      pix,
  output vga_pkg::rgb_t rgb_o,
  output logic          hsync_o,
  output logic          vsync_o,
  output logic          blank_o
);

  // Idle level of each outgoing sync
  // high for an active-low sync
  localparam logic HS_IDLE = (HPOL == 0);
  localparam logic VS_IDLE = (VPOL == 0);

  // Pipeline stage two, final registers towards the pins
  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rgb_o   <= '0;
      hsync_o <= HS_IDLE;
      vsync_o <= VS_IDLE;
      blank_o <= 1'b1;
    end else begin
      // Black outside the visible area
      rgb_o   <= pix.blank ? '0 : pix.rgb;
      // Xor with the idle level flips active-low syncs
      hsync_o <= pix.hsync ^ HS_IDLE;
      vsync_o <= pix.vsync ^ VS_IDLE;
      blank_o <= pix.blank;
    end
  end

endmodule

//--- src/vga_pattern_gen.sv
`timescale 1ns/1ps

module vga_pattern_gen #(
  parameter int HACTIVE   = 640,
  parameter int CELL_LOG2 = 5
) (
  input  logic           pclk,
  input  logic           rst_n_i,
  input  vga_pkg::mode_t mode_i,
  input  vga_pkg::rgb_t  color_i,
  vga_pos_if.dst         pos,
  vga_pixel_if.src       pix
);

  // Eight bars share the active line
  localparam int BAR_W = HACTIVE / 8;
  localparam vga_pkg::coord_t BAR_LAST = vga_pkg::coord_t'(BAR_W - 1);

  vga_pkg::mode_t  mode_q;
  vga_pkg::rgb_t   color_q;
  vga_pkg::mode_t  mode_cur;
  vga_pkg::rgb_t   color_cur;
  logic            frame_start;
  vga_pkg::coord_t bar_px_q;
  vga_pkg::coord_t bar_px_cur;
  logic [2:0]      bar_idx_q;
  logic [2:0]      bar_idx_cur;
  logic            check_bit;
  vga_pkg::chan_t  red;
  vga_pkg::chan_t  grn;
  vga_pkg::chan_t  blu;

  // First pixel of the frame
  assign frame_start = (pos.hcnt == '0) && (pos.vcnt == '0);

  // The frame's first pixel already uses the freshly sampled inputs
  assign mode_cur  = frame_start ? mode_i  : mode_q;
  assign color_cur = frame_start ? color_i : color_q;

  // Hold mode and colour for the rest of the frame
  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mode_q  <= vga_pkg::MODE_SOLID;
      color_q <= '0;
    end else if (frame_start) begin
      mode_q  <= mode_i;
      color_q <= color_i;
    end
  end

  // Bar position restarts at the left edge of every line
  assign bar_px_cur  = (pos.hcnt == '0) ? '0 : bar_px_q;
  assign bar_idx_cur = (pos.hcnt == '0) ? '0 : bar_idx_q;

  // Prepare bar position for the next pixel
  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bar_px_q  <= '0;
      bar_idx_q <= '0;
    end else if (bar_px_cur == BAR_LAST) begin
      bar_px_q  <= '0;
      bar_idx_q <= bar_idx_cur + 3'd1;
    end else begin
      bar_px_q  <= bar_px_cur + 1'b1;
      bar_idx_q <= bar_idx_cur;
    end
  end

  // Cell parity for the checkerboard
  assign check_bit = pos.hcnt[CELL_LOG2] ^ pos.vcnt[CELL_LOG2];

  always_comb begin
    red = '0;
    grn = '0;
    blu = '0;
    case (mode_cur)
      vga_pkg::MODE_SOLID: begin
        {red, grn, blu} = color_cur;
      end
      vga_pkg::MODE_BARS: begin
        // Bar index bits pick the primaries
        red = {4{bar_idx_cur[0]}};
        grn = {4{bar_idx_cur[1]}};
        blu = {4{bar_idx_cur[2]}};
      end
      vga_pkg::MODE_CHECK: begin
        red = {4{check_bit}};
        grn = {4{check_bit}};
        blu = {4{check_bit}};
      end
      default: begin
        // Gradient, blue stays at the frame colour
        red = pos.hcnt[3:0];
        grn = pos.vcnt[3:0];
        blu = color_cur[3:0];
      end
    endcase
  end

  // Pipeline stage one, colour with its own timing levels
  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pix.rgb   <= '0;
      pix.hsync <= 1'b0;
      pix.vsync <= 1'b0;
      pix.blank <= 1'b1;
    end else begin
      pix.rgb   <= {red, grn, blu};
      pix.hsync <= pos.hsync;
      pix.vsync <= pos.vsync;
      pix.blank <= pos.blank;
    end
  end

endmodule

//--- src/vga_timing.sv
`timescale 1ns/1ps

module vga_timing #(
  parameter int HACTIVE = 640,
  parameter int HFP     = 16,
  parameter int HSLEN   = 96,
  parameter int HBP     = 48,
  parameter int VACTIVE = 480,
  parameter int VFP     = 10,
  parameter int VSLEN   = 2,
  parameter int VBP     = 33
) (
  input  logic   pclk,
  input  logic   rst_n_i,
  vga_pos_if.src pos
);

  // Full line and frame lengths including blanking
  localparam int HTOTAL = HACTIVE + HFP + HSLEN + HBP;
  localparam int VTOTAL = VACTIVE + VFP + VSLEN + VBP;

  // Counter limits
  localparam vga_pkg::coord_t H_LAST = vga_pkg::coord_t'(HTOTAL - 1);
  localparam vga_pkg::coord_t V_LAST = vga_pkg::coord_t'(VTOTAL - 1);

  // Active area edges
  localparam vga_pkg::coord_t H_ACT = vga_pkg::coord_t'(HACTIVE);
  localparam vga_pkg::coord_t V_ACT = vga_pkg::coord_t'(VACTIVE);

  // Sync windows, start inclusive and end exclusive
  localparam vga_pkg::coord_t HS_START = vga_pkg::coord_t'(HACTIVE + HFP);
  localparam vga_pkg::coord_t HS_END   = vga_pkg::coord_t'(HACTIVE + HFP + HSLEN);
  localparam vga_pkg::coord_t VS_START = vga_pkg::coord_t'(VACTIVE + VFP);
  localparam vga_pkg::coord_t VS_END   = vga_pkg::coord_t'(VACTIVE + VFP + VSLEN);

  vga_pkg::coord_t hcnt_q;
  vga_pkg::coord_t vcnt_q;
  logic            h_wrap;
  logic            v_wrap;

  // End of line and end of frame
  assign h_wrap = (hcnt_q == H_LAST);
  assign v_wrap = (vcnt_q == V_LAST);

  // Pixel counter runs every clock, line counter steps at each line end
  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      hcnt_q <= '0;
      vcnt_q <= '0;
    end else begin
      if (h_wrap) begin
        hcnt_q <= '0;
        // Next line, or back to the top after the last one
        vcnt_q <= v_wrap ? '0 : vcnt_q + 1'b1;
      end else begin
        hcnt_q <= hcnt_q + 1'b1;
      end
    end
  end

  assign pos.hcnt = hcnt_q;
  assign pos.vcnt = vcnt_q;

  // Clean sync windows, polarity is applied later
  assign pos.hsync = (hcnt_q >= HS_START) && (hcnt_q < HS_END);
  assign pos.vsync = (vcnt_q >= VS_START) && (vcnt_q < VS_END);

  // Outside the visible area in either direction
  assign pos.blank = (hcnt_q >= H_ACT) || (vcnt_q >= V_ACT);

endmodule

//--- src/vga_pixel_if.sv
`timescale 1ns/1ps

// One registered pixel with its matching timing levels
// One cycle behind vga_pos_if
interface vga_pixel_if;

  // Colour for the delayed position
  vga_pkg::rgb_t rgb;

  // Delayed timing levels, still active high
  logic hsync;
  logic vsync;
  logic blank;

  // Pattern generator side
  modport src (output rgb, output hsync, output vsync, output blank);

  // Output stage side
  modport dst (input rgb, input hsync, input vsync, input blank);

endinterface

//--- src/vga_pos_if.sv
`timescale 1ns/1ps

// Raster position and raw timing levels
// Syncs here are always active high
interface vga_pos_if;

  // Current pixel and line
  vga_pkg::coord_t hcnt;
  vga_pkg::coord_t vcnt;

  // Sync windows and blanking
  logic hsync;
  logic vsync;
  logic blank;

  // Timing generator side
  modport src (output hcnt, output vcnt, output hsync, output vsync, output blank);

  // Pattern generator side
  modport dst (input hcnt, input vcnt, input hsync, input vsync, input blank);

endinterface

//--- src/vga_pkg.sv
package vga_pkg;

  // Pixel or line counter value, 0 to 2047
  typedef logic [10:0] coord_t;

  // One 4-bit colour channel
  typedef logic [3:0] chan_t;

  // 4:4:4 colour
  // red in [11:8], green in [7:4], blue in [3:0]
  typedef logic [11:0] rgb_t;

  // Pattern selector
  typedef logic [1:0] mode_t;

  // Flat colour taken from color_i
  localparam mode_t MODE_SOLID = 2'd0;

  // Eight vertical colour bars across the active line
  localparam mode_t MODE_BARS  = 2'd1;

  // Black and white checkerboard
  localparam mode_t MODE_CHECK = 2'd2;

  // Red ramps with x, green ramps with y
  localparam mode_t MODE_GRAD  = 2'd3;

endpackage
